// ==== hdl/dl_tx_pkg.sv ====
// shared widths, defaults and FIFO constants for the deterministic-latency transmit path
// referenced through scoped names such as dl_tx_pkg::SYNC_STAGES

package dl_tx_pkg;

    // boundary select is carried as a 7-bit level
    // only offsets below the word width are meaningful
    localparam int BOUNDARY_WIDTH = 7;

    // bits per serializer symbol
    localparam int SER_BASE_FACTOR_DEF = 8;

    // symbols per parallel word, so the default word is 32 bits wide
    localparam int SER_WORDS_DEF = 4;

    // phase-compensation FIFO depth, must be a power of two
    localparam int FIFO_DEPTH_DEF = 8;

    // the read side starts once this many entries are seen
    // half full leaves equal room for drift in both directions
    localparam int FIFO_START_LEVEL_DEF = 4;

    // flip-flop stages used by every clock-domain crossing
    localparam int SYNC_STAGES = 2;

endpackage

// ==== hdl/dl_reset_sync.sv ====
// reset synchronizer that asserts at once from any of its external resets
// and releases in step with clk after a short flop chain

module dl_reset_sync #(
    parameter int num_resets = 1
) (
    input  logic                  clk,
    input  logic [num_resets-1:0] ext_rst,
    output logic                  rst
);

    logic                              any_rst;
    logic [dl_tx_pkg::SYNC_STAGES-1:0] rst_chain;

    // any one of the external resets is enough to hold the domain in reset
    assign any_rst = |ext_rst;

    always_ff @(posedge clk or posedge any_rst)
    begin
        if (any_rst)
        begin
            rst_chain <= '1;
        end
        else
        begin
            // zeros shift in from the bottom so release is clean in clk
            rst_chain <= {rst_chain[dl_tx_pkg::SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign rst = rst_chain[dl_tx_pkg::SYNC_STAGES-1];

    // the output must never be low while a source reset is still high
    a_rst_follows_ext : assert property (
        @(posedge clk) (|ext_rst) |-> rst
    );

endmodule

// ==== hdl/dl_bus_sync.sv ====
// multi-stage flop synchronizer for slowly changing level values
// the payload type is a parameter so one module serves every crossing

module dl_bus_sync #(
    parameter type payload_t = logic,
    parameter int  stages    = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t dat_in,
    output payload_t dat_out
);

    payload_t sync_chain [stages];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < stages; i++)
            begin
                sync_chain[i] <= payload_t'(0);
            end
        end
        else
        begin
            // first stage may go metastable, later stages settle it
            sync_chain[0] <= dat_in;
            for (int i = 1; i < stages; i++)
            begin
                sync_chain[i] <= sync_chain[i-1];
            end
        end
    end

    assign dat_out = sync_chain[stages-1];

    // the value is expected to be quasi-static, so a change must hold for the whole chain
    a_level_stable : assert property (
        @(posedge clk) disable iff (rst)
        (dat_in != $past(dat_in)) |=> $stable(dat_in) [*(stages-1)]
    );

endmodule

// ==== hdl/dl_tx_ctrl.sv ====
// per-domain reset generation, input data register and boundary-select crossing
// sits at the front of the transmit path and feeds the FIFO write side

module dl_tx_ctrl #(
    parameter int ser_base_factor = 8,
    parameter int ser_words       = 4
) (
    input  logic                                  usr_clk,
    input  logic                                  pma_clk,
    input  logic                                  rst_usr_clk,
    input  logic                                  fifo_rst,
    input  logic [ser_base_factor*ser_words-1:0]  tx_data,
    input  logic [ser_words-1:0]                  tx_datak,
    input  logic                                  tx_data_valid,
    input  logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0]  tx_boundary_sel,
    output logic                                  usr_rst_sync,
    output logic                                  pma_rst_sync,
    output logic                                  fifo_usr_rst,
    output logic                                  fifo_pma_rst,
    output logic [ser_base_factor*ser_words-1:0]  wr_data,
    output logic [ser_words-1:0]                  wr_datak,
    output logic                                  wr_en,
    output logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0]  slip_sel
);

    localparam int WORD_W = ser_base_factor * ser_words;

    // domain resets follow only the external reset
    dl_reset_sync #(
        .num_resets (1)
    ) u_usr_rst_sync (
        .clk     (usr_clk),
        .ext_rst (rst_usr_clk),
        .rst     (usr_rst_sync)
    );

    dl_reset_sync #(
        .num_resets (1)
    ) u_pma_rst_sync (
        .clk     (pma_clk),
        .ext_rst (rst_usr_clk),
        .rst     (pma_rst_sync)
    );

    // FIFO resets also follow the separate FIFO reset input
    dl_reset_sync #(
        .num_resets (2)
    ) u_fifo_usr_rst_sync (
        .clk     (usr_clk),
        .ext_rst ({rst_usr_clk, fifo_rst}),
        .rst     (fifo_usr_rst)
    );

    dl_reset_sync #(
        .num_resets (2)
    ) u_fifo_pma_rst_sync (
        .clk     (pma_clk),
        .ext_rst ({rst_usr_clk, fifo_rst}),
        .rst     (fifo_pma_rst)
    );

    always_ff @(posedge usr_clk or posedge usr_rst_sync)
    begin
        if (usr_rst_sync)
        begin
            wr_en <= 1'b0;
        end
        else
        begin
            wr_en <= tx_data_valid;
        end
    end

    // data and k flags are only looked at when wr_en is high
    always_ff @(posedge usr_clk)
    begin
        wr_data  <= tx_data;
        wr_datak <= tx_datak;
    end

    // boundary select is a level set by software, a plain flop chain is enough
    dl_bus_sync #(
        .payload_t (logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0]),
        .stages    (dl_tx_pkg::SYNC_STAGES)
    ) u_boundary_sync (
        .clk     (pma_clk),
        .rst     (pma_rst_sync),
        .dat_in  (tx_boundary_sel),
        .dat_out (slip_sel)
    );

    a_boundary_in_range : assert property (
        @(posedge usr_clk) disable iff (usr_rst_sync)
        tx_boundary_sel < WORD_W
    );

endmodule

// ==== hdl/dl_tx_phase_fifo.sv ====
// dual-clock phase-compensation FIFO between usr_clk and pma_clk
// reading starts at a fixed fill level and then runs every pma_clk cycle

module dl_tx_phase_fifo #(
    parameter int ser_base_factor = 8,
    parameter int ser_words       = 4,
    parameter int fifo_depth      = 8,
    parameter int start_level     = 4
) (
    input  logic                                 usr_clk,
    input  logic                                 pma_clk,
    input  logic                                 wr_rst,
    input  logic                                 rd_rst,
    input  logic                                 wr_en,
    input  logic [ser_base_factor*ser_words-1:0] wr_data,
    input  logic [ser_words-1:0]                 wr_datak,
    output logic [ser_base_factor*ser_words-1:0] rd_data,
    output logic [ser_words-1:0]                 rd_datak,
    output logic                                 rd_valid,
    output logic                                 fifo_err
);

    localparam int WORD_W = ser_base_factor * ser_words;
    localparam int AW     = $clog2(fifo_depth);
    localparam int PW     = AW + 1;

    function automatic logic [PW-1:0] gray_to_bin(input logic [PW-1:0] gray);
        logic [PW-1:0] bin;
        bin[PW-1] = gray[PW-1];
        for (int i = PW - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // data and k flags share one entry
    logic [ser_words+WORD_W-1:0] mem [fifo_depth];

    logic [PW-1:0] wr_bin;
    logic [PW-1:0] wr_gray;
    logic [PW-1:0] rd_gray_s1;
    logic [PW-1:0] rd_gray_s2;
    logic          full;
    logic          wr_err;

    logic [PW-1:0] rd_bin;
    logic [PW-1:0] rd_gray;
    logic [PW-1:0] wr_gray_s1;
    logic [PW-1:0] wr_gray_s2;
    logic [PW-1:0] fill;
    logic          reading;
    logic          wr_err_s1;
    logic          wr_err_s2;

    // write side in usr_clk
    assign full = (wr_bin - gray_to_bin(rd_gray_s2)) == PW'(fifo_depth);

    always_ff @(posedge usr_clk)
    begin
        if (wr_en && !full)
        begin
            mem[wr_bin[AW-1:0]] <= {wr_datak, wr_data};
        end
    end

    always_ff @(posedge usr_clk or posedge wr_rst)
    begin
        if (wr_rst)
        begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            wr_err     <= 1'b0;
        end
        else
        begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_en && !full)
            begin
                wr_bin  <= wr_bin + 1'b1;
                wr_gray <= (wr_bin + 1'b1) ^ ((wr_bin + 1'b1) >> 1);
            end
            // overflow drops the word and is remembered until a FIFO reset
            if (wr_en && full)
            begin
                wr_err <= 1'b1;
            end
        end
    end

    // read side in pma_clk
    assign fill = gray_to_bin(wr_gray_s2) - rd_bin;

    always_ff @(posedge pma_clk or posedge rd_rst)
    begin
        if (rd_rst)
        begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            wr_err_s1  <= 1'b0;
            wr_err_s2  <= 1'b0;
            reading    <= 1'b0;
            rd_valid   <= 1'b0;
            fifo_err   <= 1'b0;
        end
        else
        begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            wr_err_s1  <= wr_err;
            wr_err_s2  <= wr_err_s1;

            // once the start level is seen, reading never pauses again
            if (fill >= PW'(start_level))
            begin
                reading <= 1'b1;
            end

            rd_valid <= 1'b0;
            if (reading && fill != '0)
            begin
                rd_bin   <= rd_bin + 1'b1;
                rd_gray  <= (rd_bin + 1'b1) ^ ((rd_bin + 1'b1) >> 1);
                rd_valid <= 1'b1;
            end

            // underflow or a crossed overflow both land in the same sticky flag
            if ((reading && fill == '0) || wr_err_s2)
            begin
                fifo_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge pma_clk)
    begin
        {rd_datak, rd_data} <= mem[rd_bin[AW-1:0]];
    end

    a_start_below_depth : assert property (
        @(posedge pma_clk) start_level < fifo_depth
    );

endmodule

// ==== hdl/dl_tx_word_slip.sv ====
// word-boundary slip on the pma_clk side
// the output window straddles the previous and current word, offset by slip_sel bits

module dl_tx_word_slip #(
    parameter int ser_base_factor = 8,
    parameter int ser_words       = 4
) (
    input  logic                                 pma_clk,
    input  logic                                 rst,
    input  logic [ser_base_factor*ser_words-1:0] in_data,
    input  logic [ser_words-1:0]                 in_datak,
    input  logic                                 in_valid,
    input  logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0] slip_sel,
    output logic [ser_base_factor*ser_words-1:0] pcs_data,
    output logic [ser_words-1:0]                 pcs_datak,
    output logic                                 pcs_valid
);

    localparam int WORD_W = ser_base_factor * ser_words;

    logic [WORD_W-1:0]    prev_data;
    logic [ser_words-1:0] prev_datak;
    logic                 prev_valid;
    logic [2*WORD_W-1:0]  pair;
    logic [2*WORD_W-1:0]  shifted;

    // previous word in the low half, current word in the high half
    assign pair    = {in_data, prev_data};
    assign shifted = pair >> slip_sel;

    always_ff @(posedge pma_clk or posedge rst)
    begin
        if (rst)
        begin
            prev_valid <= 1'b0;
            pcs_valid  <= 1'b0;
        end
        else
        begin
            prev_valid <= in_valid;
            // both halves of the window have to be real words
            pcs_valid  <= prev_valid & in_valid;
        end
    end

    always_ff @(posedge pma_clk)
    begin
        prev_data <= in_data;
        prev_datak <= in_datak;
        pcs_data  <= shifted[WORD_W-1:0];
        // k flags ride along with the previous word and are not shifted
        pcs_datak <= prev_datak;
    end

endmodule

// ==== hdl/dl_tx_top.sv ====
// top level of the deterministic-latency transmit path
// connects control, phase FIFO, word slip and the error-flag crossing

module dl_tx_top #(
    parameter int ser_base_factor = dl_tx_pkg::SER_BASE_FACTOR_DEF,
    parameter int ser_words       = dl_tx_pkg::SER_WORDS_DEF,
    parameter int fifo_depth      = dl_tx_pkg::FIFO_DEPTH_DEF,
    parameter int start_level     = dl_tx_pkg::FIFO_START_LEVEL_DEF
) (
    input  logic                                 usr_clk,
    input  logic                                 pma_clk,
    input  logic                                 rst_usr_clk,
    input  logic                                 fifo_rst,
    input  logic [ser_base_factor*ser_words-1:0] tx_data,
    input  logic [ser_words-1:0]                 tx_datak,
    input  logic                                 tx_data_valid,
    input  logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0] tx_boundary_sel,
    output logic [ser_base_factor*ser_words-1:0] pcs_data,
    output logic [ser_words-1:0]                 pcs_datak,
    output logic                                 pcs_valid,
    output logic                                 fifo_error
);

    localparam int WORD_W = ser_base_factor * ser_words;

    logic                                 usr_rst_sync;
    logic                                 pma_rst_sync;
    logic                                 fifo_usr_rst;
    logic                                 fifo_pma_rst;
    logic [WORD_W-1:0]                    wr_data;
    logic [ser_words-1:0]                 wr_datak;
    logic                                 wr_en;
    logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0] slip_sel;
    logic [WORD_W-1:0]                    rd_data;
    logic [ser_words-1:0]                 rd_datak;
    logic                                 rd_valid;
    logic                                 fifo_err_pma;

    dl_tx_ctrl #(
        .ser_base_factor (ser_base_factor),
        .ser_words       (ser_words)
    ) u_ctrl (
        .usr_clk         (usr_clk),
        .pma_clk         (pma_clk),
        .rst_usr_clk     (rst_usr_clk),
        .fifo_rst        (fifo_rst),
        .tx_data         (tx_data),
        .tx_datak        (tx_datak),
        .tx_data_valid   (tx_data_valid),
        .tx_boundary_sel (tx_boundary_sel),
        .usr_rst_sync    (usr_rst_sync),
        .pma_rst_sync    (pma_rst_sync),
        .fifo_usr_rst    (fifo_usr_rst),
        .fifo_pma_rst    (fifo_pma_rst),
        .wr_data         (wr_data),
        .wr_datak        (wr_datak),
        .wr_en           (wr_en),
        .slip_sel        (slip_sel)
    );

    dl_tx_phase_fifo #(
        .ser_base_factor (ser_base_factor),
        .ser_words       (ser_words),
        .fifo_depth      (fifo_depth),
        .start_level     (start_level)
    ) u_fifo (
        .usr_clk  (usr_clk),
        .pma_clk  (pma_clk),
        .wr_rst   (fifo_usr_rst),
        .rd_rst   (fifo_pma_rst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .wr_datak (wr_datak),
        .rd_data  (rd_data),
        .rd_datak (rd_datak),
        .rd_valid (rd_valid),
        .fifo_err (fifo_err_pma)
    );

    dl_tx_word_slip #(
        .ser_base_factor (ser_base_factor),
        .ser_words       (ser_words)
    ) u_word_slip (
        .pma_clk   (pma_clk),
        .rst       (pma_rst_sync),
        .in_data   (rd_data),
        .in_datak  (rd_datak),
        .in_valid  (rd_valid),
        .slip_sel  (slip_sel),
        .pcs_data  (pcs_data),
        .pcs_datak (pcs_datak),
        .pcs_valid (pcs_valid)
    );

    // sticky error is a level, so a flop chain brings it back to usr_clk
    dl_bus_sync #(
        .payload_t (logic),
        .stages    (dl_tx_pkg::SYNC_STAGES)
    ) u_err_sync (
        .clk     (usr_clk),
        .rst     (usr_rst_sync),
        .dat_in  (fifo_err_pma),
        .dat_out (fifo_error)
    );

endmodule

// ==== tests/tb_dl_tx_top.sv ====
// directed testbench for the transmit path, run with src.f and tb_dl_tx_top as top
// covers idle after reset, plain and slipped streams, underflow and FIFO reset recovery

module tb_dl_tx_top;

    localparam int WORD_W        = dl_tx_pkg::SER_BASE_FACTOR_DEF * dl_tx_pkg::SER_WORDS_DEF;
    localparam int K_W           = dl_tx_pkg::SER_WORDS_DEF;
    localparam int TB_FIFO_DEPTH = 16;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 20;
    localparam int LEN_PLAIN     = 24;
    localparam int LEN_SLIP      = 24;
    localparam int LEN_DRAIN     = 16;
    localparam int LEN_RECOVER   = 20;
    localparam int TEST_OVERHEAD = 100;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + LEN_PLAIN + LEN_SLIP
                                   + LEN_DRAIN + LEN_RECOVER + 4 * TEST_OVERHEAD + 200;

    logic              usr_clk;
    logic              pma_clk;
    logic              rst_usr_clk;
    logic              fifo_rst;
    logic [WORD_W-1:0] tx_data;
    logic [K_W-1:0]    tx_datak;
    logic              tx_data_valid;
    logic [dl_tx_pkg::BOUNDARY_WIDTH-1:0] tx_boundary_sel;
    logic [WORD_W-1:0] pcs_data;
    logic [K_W-1:0]    pcs_datak;
    logic              pcs_valid;
    logic              fifo_error;

    logic [WORD_W-1:0] sent_data [$];
    logic [K_W-1:0]    sent_k [$];
    logic [WORD_W-1:0] got_data [$];
    logic [K_W-1:0]    got_k [$];
    int                errors;
    int                checks;
    int                active_slip;

    // the pointer round trip through both crossings needs more than eight entries
    // at this start level when writes and reads both run every cycle
    dl_tx_top #(
        .fifo_depth (TB_FIFO_DEPTH)
    ) u_dut (
        .usr_clk         (usr_clk),
        .pma_clk         (pma_clk),
        .rst_usr_clk     (rst_usr_clk),
        .fifo_rst        (fifo_rst),
        .tx_data         (tx_data),
        .tx_datak        (tx_datak),
        .tx_data_valid   (tx_data_valid),
        .tx_boundary_sel (tx_boundary_sel),
        .pcs_data        (pcs_data),
        .pcs_datak       (pcs_datak),
        .pcs_valid       (pcs_valid),
        .fifo_error      (fifo_error)
    );

    initial
    begin
        usr_clk = 1'b0;
        forever #10 usr_clk = ~usr_clk;
    end

    // same period as usr_clk, rising edges 7 units later
    initial
    begin
        pma_clk = 1'b0;
        #7;
        forever #10 pma_clk = ~pma_clk;
    end

    // outputs are settled at the falling edge of pma_clk
    always @(negedge pma_clk)
    begin
        if (pcs_valid === 1'b1)
        begin
            got_data.push_back(pcs_data);
            got_k.push_back(pcs_datak);
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge usr_clk);
        $display("watchdog expired after %0d usr_clk cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // window of word width starting s bits up, previous word low, current word high
    function automatic logic [WORD_W-1:0] slip_window(input logic [WORD_W-1:0] prev_word,
                                                      input logic [WORD_W-1:0] cur_word,
                                                      input int s);
        logic [WORD_W-1:0] win;
        int                src;
        for (int i = 0; i < WORD_W; i++)
        begin
            src = i + s;
            if (src < WORD_W)
                win[i] = prev_word[src];
            else
                win[i] = cur_word[src - WORD_W];
        end
        return win;
    endfunction

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errors_before);
    endtask

    task automatic set_slip(input int s);
        @(posedge usr_clk);
        tx_boundary_sel <= dl_tx_pkg::BOUNDARY_WIDTH'(s);
        active_slip = s;
        repeat (6) @(posedge usr_clk);
    endtask

    task automatic pulse_fifo_reset();
        @(posedge usr_clk);
        fifo_rst <= 1'b1;
        repeat (4) @(posedge usr_clk);
        fifo_rst <= 1'b0;
        repeat (8) @(posedge usr_clk);
    endtask

    task automatic send_stream(input int n);
        logic [WORD_W-1:0] d;
        logic [K_W-1:0]    k;
        sent_data.delete();
        sent_k.delete();
        got_data.delete();
        got_k.delete();
        for (int i = 0; i < n; i++)
        begin
            d = $urandom;
            k = K_W'($urandom);
            @(posedge usr_clk);
            tx_data       <= d;
            tx_datak      <= k;
            tx_data_valid <= 1'b1;
            sent_data.push_back(d);
            sent_k.push_back(k);
        end
        @(posedge usr_clk);
        tx_data_valid <= 1'b0;
    endtask

    // n sent words give n-1 windows, each pairing a word with its successor
    task automatic check_windows();
        int                expected_count;
        int                waited;
        logic [WORD_W-1:0] exp_data;
        expected_count = sent_data.size() - 1;
        waited = 0;
        while (got_data.size() < expected_count && waited < expected_count + 60)
        begin
            @(posedge pma_clk);
            waited++;
        end
        repeat (12) @(posedge pma_clk);
        checks++;
        if (got_data.size() < expected_count)
        begin
            $display("timeout: only %0d of %0d output words arrived",
                     got_data.size(), expected_count);
            errors++;
        end
        else if (got_data.size() > expected_count)
        begin
            $display("too many output words: expected %0d, got %0d",
                     expected_count, got_data.size());
            errors++;
        end
        for (int j = 0; j < expected_count && j < got_data.size(); j++)
        begin
            exp_data = slip_window(sent_data[j], sent_data[j+1], active_slip);
            checks++;
            if (got_data[j] !== exp_data)
            begin
                $display("MISMATCH pcs_data word %0d: expected %h, got %h",
                         j, exp_data, got_data[j]);
                errors++;
            end
            if (got_k[j] !== sent_k[j])
            begin
                $display("MISMATCH pcs_datak word %0d: expected %h, got %h",
                         j, sent_k[j], got_k[j]);
                errors++;
            end
        end
    endtask

    task automatic idle_after_reset();
        int errors_before;
        errors_before = errors;
        repeat (IDLE_CYCLES)
        begin
            @(negedge usr_clk);
            checks++;
            if (pcs_valid !== 1'b0)
            begin
                $display("MISMATCH pcs_valid: expected %h, got %h", 1'b0, pcs_valid);
                errors++;
            end
            if (fifo_error !== 1'b0)
            begin
                $display("MISMATCH fifo_error: expected %h, got %h", 1'b0, fifo_error);
                errors++;
            end
        end
        report_test("idle after reset", errors_before);
    endtask

    task automatic stream_without_slip();
        int errors_before;
        errors_before = errors;
        set_slip(0);
        pulse_fifo_reset();
        send_stream(LEN_PLAIN);
        check_windows();
        report_test("stream without slip", errors_before);
    endtask

    task automatic stream_with_slip();
        int errors_before;
        errors_before = errors;
        set_slip(13);
        pulse_fifo_reset();
        send_stream(LEN_SLIP);
        check_windows();
        report_test("stream with slip", errors_before);
    endtask

    task automatic drain_to_underflow();
        int errors_before;
        int waited;
        errors_before = errors;
        pulse_fifo_reset();
        send_stream(LEN_DRAIN);
        // the FIFO still holds words here, so no error may be flagged yet
        @(negedge usr_clk);
        checks++;
        if (fifo_error !== 1'b0)
        begin
            $display("MISMATCH fifo_error: expected %h, got %h", 1'b0, fifo_error);
            errors++;
        end
        check_windows();
        waited = 0;
        while (fifo_error !== 1'b1 && waited < 30)
        begin
            @(negedge usr_clk);
            waited++;
        end
        checks++;
        if (fifo_error !== 1'b1)
        begin
            $display("fifo_error did not rise after the FIFO ran empty");
            errors++;
        end
        report_test("drain to underflow", errors_before);
    endtask

    task automatic recover_after_fifo_reset();
        int errors_before;
        int waited;
        errors_before = errors;
        checks++;
        if (fifo_error !== 1'b1)
        begin
            $display("fifo_error was not set before the FIFO reset");
            errors++;
        end
        // keep words flowing so that the reset has live output to clear
        repeat (10)
        begin
            @(posedge usr_clk);
            tx_data       <= $urandom;
            tx_datak      <= '0;
            tx_data_valid <= 1'b1;
        end
        fifo_rst <= 1'b1;
        repeat (4) @(posedge usr_clk);
        tx_data_valid <= 1'b0;
        @(negedge usr_clk);
        checks++;
        if (pcs_valid !== 1'b0)
        begin
            $display("MISMATCH pcs_valid: expected %h, got %h", 1'b0, pcs_valid);
            errors++;
        end
        @(posedge usr_clk);
        fifo_rst <= 1'b0;
        waited = 0;
        while (fifo_error !== 1'b0 && waited < 20)
        begin
            @(negedge usr_clk);
            waited++;
        end
        checks++;
        if (fifo_error !== 1'b0)
        begin
            $display("fifo_error stayed high after the FIFO reset");
            errors++;
        end
        set_slip(21);
        send_stream(LEN_RECOVER);
        check_windows();
        report_test("recover after fifo reset", errors_before);
    endtask

    initial
    begin
        int rng_state;
        rng_state = $urandom(67);
        errors = 0;
        checks = 0;
        active_slip = 0;
        rst_usr_clk     <= 1'b1;
        fifo_rst        <= 1'b0;
        tx_data         <= '0;
        tx_datak        <= '0;
        tx_data_valid   <= 1'b0;
        tx_boundary_sel <= '0;
        repeat (RESET_CYCLES) @(posedge usr_clk);
        rst_usr_clk <= 1'b0;
        repeat (4) @(posedge usr_clk);

        idle_after_reset();
        stream_without_slip();
        stream_with_slip();
        drain_to_underflow();
        recover_after_fifo_reset();

        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== src.f ====
hdl/dl_tx_pkg.sv
hdl/dl_reset_sync.sv
hdl/dl_bus_sync.sv
hdl/dl_tx_ctrl.sv
hdl/dl_tx_phase_fifo.sv
hdl/dl_tx_word_slip.sv
hdl/dl_tx_top.sv
tests/tb_dl_tx_top.sv

// ==== Bender.yml ====
package:
  name: dl_tx

sources:
  - hdl/dl_tx_pkg.sv
  - hdl/dl_reset_sync.sv
  - hdl/dl_bus_sync.sv
  - hdl/dl_tx_ctrl.sv
  - hdl/dl_tx_phase_fifo.sv
  - hdl/dl_tx_word_slip.sv
  - hdl/dl_tx_top.sv
  - target: test
    files:
      - tests/tb_dl_tx_top.sv
